// File: common/adcfifo_pkg.sv
// sizes are fixed here; MEM_RATIO, RELEASE_GROUP and OBUF_DEPTH must stay powers of two
`default_nettype none

package adcfifo_pkg;

  // **************************************************
  // sizes
  // **************************************************

  // one wide ADC sample and one narrow DMA word
  localparam int ADC_DATA_WIDTH = 64;
  localparam int DMA_DATA_WIDTH = 16;

  // narrow words per sample, lowest lane read first
  localparam int MEM_RATIO = ADC_DATA_WIDTH / DMA_DATA_WIDTH;
  localparam int LANE_BITS = $clog2(MEM_RATIO);

  // capture depth in samples and in words
  localparam int ADC_ADDR_WIDTH = 6;
  localparam int ADC_DEPTH = 2 ** ADC_ADDR_WIDTH;
  localparam int DMA_ADDR_WIDTH = ADC_ADDR_WIDTH + LANE_BITS;
  localparam int DMA_DEPTH = 2 ** DMA_ADDR_WIDTH;

  // samples written between two releases to the DMA side
  localparam int RELEASE_GROUP = 8;
  localparam int GROUP_BITS = $clog2(RELEASE_GROUP);

  // output buffer entries
  localparam int OBUF_DEPTH = 4;
  localparam int OBUF_PTR_BITS = $clog2(OBUF_DEPTH);

  // **************************************************
  // types
  // **************************************************

  typedef logic [ADC_DATA_WIDTH-1:0] adc_sample_t;
  typedef logic [DMA_DATA_WIDTH-1:0] dma_word_t;
  typedef logic [ADC_ADDR_WIDTH-1:0] adc_addr_t;
  typedef logic [DMA_ADDR_WIDTH-1:0] dma_addr_t;

  // released sample count, 0 up to ADC_DEPTH inclusive
  typedef logic [ADC_ADDR_WIDTH:0] rel_count_t;

  // word position, 0 up to DMA_DEPTH inclusive
  typedef logic [DMA_ADDR_WIDTH:0] dma_count_t;

  // output buffer pointer and occupancy
  typedef logic [OBUF_PTR_BITS-1:0] obuf_ptr_t;
  typedef logic [OBUF_PTR_BITS:0] obuf_count_t;

  // write command into the wide RAM port
  typedef struct packed {
    logic        en;
    adc_addr_t   addr;
    adc_sample_t data;
  } mem_wr_t;

  // progress handed to the DMA side; count only moves with a toggle flip
  typedef struct packed {
    logic       toggle;
    rel_count_t count;
  } wr_release_t;

endpackage

`default_nettype wire

// File: design/asym_dpram.sv
// no read-during-write protection; the caller only reads rows that were released after writing
`timescale 1ns/1ns
`default_nettype none

module asym_dpram (
  input  logic                   adc_clk,
  input  adcfifo_pkg::mem_wr_t   mem_wr,
  input  logic                   dma_clk,
  input  adcfifo_pkg::dma_addr_t rd_addr,
  output adcfifo_pkg::dma_word_t rd_data
);

  import adcfifo_pkg::*;

  // each row holds one sample split into narrow lanes, lane 0 in the low bits
  logic [MEM_RATIO-1:0][DMA_DATA_WIDTH-1:0] mem [ADC_DEPTH];

  // read side
  dma_addr_t            rd_addr_q;
  adc_addr_t            rd_row;
  logic [LANE_BITS-1:0] rd_lane;

  // **************************************************
  // wide write port
  // **************************************************

  always_ff @(posedge adc_clk) begin
    if (mem_wr.en) begin
      mem[mem_wr.addr] <= mem_wr.data;
    end
  end

  // **************************************************
  // narrow read port
  // **************************************************

  // upper address bits pick the sample, low bits the lane
  assign rd_row = rd_addr_q[DMA_ADDR_WIDTH-1:LANE_BITS];
  assign rd_lane = rd_addr_q[LANE_BITS-1:0];

  // registered address, then registered data: two cycles from rd_addr
  always_ff @(posedge dma_clk) begin
    rd_addr_q <= rd_addr;
    rd_data <= mem[rd_row][rd_lane];
  end

endmodule

`default_nettype wire

// File: adc_capture/adc_capture_ctrl.sv
// dma_xfer_req is asynchronous to adc_clk; one capture of up to ADC_DEPTH samples per request rise
`timescale 1ns/1ns
`default_nettype none

module adc_capture_ctrl (
  input  logic                     adc_clk,
  input  logic                     adc_rst,
  input  logic                     dma_xfer_req,
  input  logic                     adc_wr,
  input  adcfifo_pkg::adc_sample_t adc_wdata,
  output adcfifo_pkg::mem_wr_t     mem_wr,
  output adcfifo_pkg::wr_release_t release_out
);

  import adcfifo_pkg::*;

  // request synchronizer, bit 2 is the edge register
  logic [2:0]  req_m;
  logic        xfer_init;

  // capture state
  logic        capture_en;
  logic        accept;
  adc_addr_t   acc_addr;

  // registered write command
  logic        wr_en;
  adc_addr_t   wr_addr;
  adc_sample_t wr_data;
  logic        group_done;

  // release to the DMA side
  logic        rel_toggle;
  rel_count_t  rel_count;

  assign xfer_init = req_m[1] & ~req_m[2];
  assign accept = adc_wr & capture_en;
  assign group_done = wr_en && (wr_addr[GROUP_BITS-1:0] == GROUP_BITS'(RELEASE_GROUP - 1));

  // **************************************************
  // request sync and capture enable
  // **************************************************

  always_ff @(posedge adc_clk or posedge adc_rst) begin
    if (adc_rst) begin
      req_m <= '0;
      capture_en <= 1'b0;
      acc_addr <= '0;
    end else begin
      req_m <= {req_m[1:0], dma_xfer_req};
      if (xfer_init) begin
        // new capture always starts at sample 0
        capture_en <= 1'b1;
        acc_addr <= '0;
      end else begin
        // stop on the last sample or when the request drops
        if (!req_m[1] || (accept && (acc_addr == adc_addr_t'(ADC_DEPTH - 1)))) begin
          capture_en <= 1'b0;
        end
        if (accept) begin
          acc_addr <= acc_addr + 1'b1;
        end
      end
    end
  end

  // **************************************************
  // write command, one cycle after the sample
  // **************************************************

  always_ff @(posedge adc_clk or posedge adc_rst) begin
    if (adc_rst) begin
      wr_en <= 1'b0;
      wr_addr <= '0;
    end else begin
      wr_en <= accept;
      if (accept) begin
        wr_addr <= acc_addr;
      end
    end
  end

  // sample payload
  always_ff @(posedge adc_clk) begin
    if (accept) begin
      wr_data <= adc_wdata;
    end
  end

  assign mem_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

  // **************************************************
  // release toggle
  // **************************************************

  // flips together with the RAM write of the last sample in a group
  always_ff @(posedge adc_clk or posedge adc_rst) begin
    if (adc_rst) begin
      rel_toggle <= 1'b0;
      rel_count <= '0;
    end else if (group_done) begin
      rel_toggle <= ~rel_toggle;
      rel_count <= {1'b0, wr_addr} + 1'b1;
    end
  end

  assign release_out = '{toggle: rel_toggle, count: rel_count};

endmodule

`default_nettype wire

// File: dma_readout/dma_read_ctrl.sv
// dma_clk domain, cleared while dma_xfer_req is low; release_in must come from adc_capture_ctrl
`timescale 1ns/1ns
`default_nettype none

module dma_read_ctrl (
  input  logic                     dma_clk,
  input  logic                     dma_xfer_req,
  input  adcfifo_pkg::wr_release_t release_in,
  input  adcfifo_pkg::dma_word_t   rd_data,
  input  logic                     buf_pop,
  output adcfifo_pkg::dma_addr_t   rd_addr,
  output logic                     buf_push,
  output adcfifo_pkg::dma_word_t   buf_word
);

  import adcfifo_pkg::*;

  // toggle synchronizer, bit 2 is the edge register
  logic [2:0]  tog_m;
  logic        rel_edge;
  rel_count_t  rel_count;

  // read position and limit in words
  dma_count_t  rd_limit;
  dma_count_t  rd_ptr;
  logic        rd_issue;

  // words in the buffer plus reads still in the RAM pipe
  obuf_count_t credit_used;

  // RAM latency tracking
  logic        rd_v1;
  logic        rd_v2;

  assign rel_edge = tog_m[2] ^ tog_m[1];

  // samples released times MEM_RATIO
  assign rd_limit = {rel_count, {LANE_BITS{1'b0}}};

  assign rd_issue = (rd_ptr < rd_limit) && (rd_ptr < dma_count_t'(DMA_DEPTH)) &&
                    (credit_used < obuf_count_t'(OBUF_DEPTH));

  // **************************************************
  // release synchronizer
  // **************************************************

  // keeps following the write side even while idle, so an old toggle
  // level is not taken as a fresh release when the request rises
  always_ff @(posedge dma_clk) begin
    tog_m <= {tog_m[1:0], release_in.toggle};
  end

  // **************************************************
  // read issue and pipeline
  // **************************************************

  always_ff @(posedge dma_clk) begin
    if (!dma_xfer_req) begin
      rel_count <= '0;
      rd_ptr <= '0;
      credit_used <= '0;
      rd_v1 <= 1'b0;
      rd_v2 <= 1'b0;
    end else begin
      // count is stable by the time the edge shows up here
      if (rel_edge) begin
        rel_count <= release_in.count;
      end
      if (rd_issue) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      rd_v1 <= rd_issue;
      rd_v2 <= rd_v1;
      case ({rd_issue, buf_pop})
        2'b10:   credit_used <= credit_used + 1'b1;
        2'b01:   credit_used <= credit_used - 1'b1;
        default: credit_used <= credit_used;
      endcase
    end
  end

  assign rd_addr = rd_ptr[DMA_ADDR_WIDTH-1:0];

  // RAM data lines up with the second pipeline stage
  assign buf_push = rd_v2;
  assign buf_word = rd_data;

endmodule

`default_nettype wire

// File: dma_readout/dma_stream_buffer.sv
// never pushed while full; the read side holds credit against OBUF_DEPTH
`timescale 1ns/1ns
`default_nettype none

module dma_stream_buffer (
  input  logic                   dma_clk,
  input  logic                   dma_xfer_req,
  input  logic                   buf_push,
  input  adcfifo_pkg::dma_word_t buf_word,
  input  logic                   dma_ready,
  output logic                   buf_pop,
  output logic                   dma_valid,
  output adcfifo_pkg::dma_word_t dma_data
);

  import adcfifo_pkg::*;

  // ring storage
  dma_word_t   entries [OBUF_DEPTH];

  // ring control
  obuf_ptr_t   wr_ptr;
  obuf_ptr_t   rd_ptr;
  obuf_count_t count;
  logic        pop;

  // **************************************************
  // stream side
  // **************************************************

  // head word stays put until it is taken
  assign dma_valid = (count != '0);
  assign dma_data = entries[rd_ptr];
  assign pop = dma_valid & dma_ready;

  // tells the read side a credit is free again
  assign buf_pop = pop;

  // **************************************************
  // ring control
  // **************************************************

  always_ff @(posedge dma_clk) begin
    if (!dma_xfer_req) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      // pointers wrap on their own, depth is a power of two
      if (buf_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({buf_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry storage
  always_ff @(posedge dma_clk) begin
    if (buf_push) begin
      entries[wr_ptr] <= buf_word;
    end
  end

endmodule

`default_nettype wire

// File: design/adc_capture_fifo.sv
// two unrelated clocks; adc_rst covers the adc_clk side only, dma side clears on dma_xfer_req low
`timescale 1ns/1ns
`default_nettype none

module adc_capture_fifo (
  // adc side
  input  logic                     adc_clk,
  input  logic                     adc_rst,
  input  logic                     adc_wr,
  input  adcfifo_pkg::adc_sample_t adc_wdata,

  // dma side
  input  logic                     dma_clk,
  input  logic                     dma_xfer_req,
  output logic                     dma_valid,
  output adcfifo_pkg::dma_word_t   dma_data,
  input  logic                     dma_ready
);

  import adcfifo_pkg::*;

  // adc_clk domain
  mem_wr_t     mem_wr;

  // crosses into dma_clk
  wr_release_t wr_release;

  // dma_clk domain
  dma_addr_t   rd_addr;
  dma_word_t   rd_data;
  logic        buf_push;
  dma_word_t   buf_word;
  logic        buf_pop;

  // **************************************************
  // write side
  // **************************************************

  adc_capture_ctrl u_adc_capture_ctrl (
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .dma_xfer_req (dma_xfer_req),
    .adc_wr       (adc_wr),
    .adc_wdata    (adc_wdata),
    .mem_wr       (mem_wr),
    .release_out  (wr_release)
  );

  asym_dpram u_asym_dpram (
    .adc_clk (adc_clk),
    .mem_wr  (mem_wr),
    .dma_clk (dma_clk),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // **************************************************
  // read side
  // **************************************************

  dma_read_ctrl u_dma_read_ctrl (
    .dma_clk      (dma_clk),
    .dma_xfer_req (dma_xfer_req),
    .release_in   (wr_release),
    .rd_data      (rd_data),
    .buf_pop      (buf_pop),
    .rd_addr      (rd_addr),
    .buf_push     (buf_push),
    .buf_word     (buf_word)
  );

  dma_stream_buffer u_dma_stream_buffer (
    .dma_clk      (dma_clk),
    .dma_xfer_req (dma_xfer_req),
    .buf_push     (buf_push),
    .buf_word     (buf_word),
    .dma_ready    (dma_ready),
    .buf_pop      (buf_pop),
    .dma_valid    (dma_valid),
    .dma_data     (dma_data)
  );

endmodule

`default_nettype wire

// File: verification/adc_capture_fifo_sva.sv
// bound into adc_capture_fifo; stream checks are skipped while dma_xfer_req is low
`timescale 1ns/1ns
`default_nettype none

module adc_capture_fifo_sva (
  input logic                   adc_clk,
  input logic                   adc_rst,
  input adcfifo_pkg::mem_wr_t   mem_wr,
  input logic                   dma_clk,
  input logic                   dma_xfer_req,
  input logic                   dma_valid,
  input adcfifo_pkg::dma_word_t dma_data,
  input logic                   dma_ready
);

  // a stalled word holds until it is taken
  property stall_hold;
    @(posedge dma_clk) disable iff (!dma_xfer_req)
      (dma_valid && !dma_ready) |=> (dma_valid && $stable(dma_data));
  endproperty

  // dma side has cleared one edge after it sees the request low
  property idle_quiet;
    @(posedge dma_clk) !dma_xfer_req |=> !dma_valid;
  endproperty

  // wide port stays silent in reset
  property no_write_in_reset;
    @(posedge adc_clk) adc_rst |-> !mem_wr.en;
  endproperty

  a_stall_hold: assert property (stall_hold)
    else $error("dma_valid or dma_data changed during a stall");
  a_idle_quiet: assert property (idle_quiet)
    else $error("dma_valid high while dma_xfer_req is low");
  a_no_write_in_reset: assert property (no_write_in_reset)
    else $error("RAM write while adc_rst is high");

endmodule

bind adc_capture_fifo adc_capture_fifo_sva u_adc_capture_fifo_sva (
  .adc_clk      (adc_clk),
  .adc_rst      (adc_rst),
  .mem_wr       (mem_wr),
  .dma_clk      (dma_clk),
  .dma_xfer_req (dma_xfer_req),
  .dma_valid    (dma_valid),
  .dma_data     (dma_data),
  .dma_ready    (dma_ready)
);

`default_nettype wire

// File: verification/tb_adc_capture_fifo.sv
// random stimulus from seed 16; the request only drops after a capture has fully drained
`timescale 1ns/1ns
`default_nettype none

module tb_adc_capture_fifo;

  import adcfifo_pkg::*;

  localparam int ADC_HALF = 20;
  localparam int DMA_HALF = 14;
  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 8;
  localparam int ENABLE_DELAY = 3;
  localparam int WAIT_LIMIT = 4000;
  localparam int SEED = 16;

  // DUT ports
  logic        adc_clk;
  logic        adc_rst;
  logic        adc_wr;
  adc_sample_t adc_wdata;
  logic        dma_clk;
  logic        dma_xfer_req;
  logic        dma_valid;
  dma_word_t   dma_data;
  logic        dma_ready;

  // one random stream per clock domain, so draw order never depends on the scheduler
  int          wr_seed;
  int          ready_seed;
  logic        ready_random;

  // reference model
  dma_word_t   exp_words[$];
  int          req_edges;
  logic        mdl_en;
  int          cap_cnt;

  // results
  string       test_name;
  int          got_cnt;
  int          word_errs;
  int          count_errs;
  int          valid_errs;
  int          other_errs;

  adc_capture_fifo u_adc_capture_fifo (
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .adc_wr       (adc_wr),
    .adc_wdata    (adc_wdata),
    .dma_clk      (dma_clk),
    .dma_xfer_req (dma_xfer_req),
    .dma_valid    (dma_valid),
    .dma_data     (dma_data),
    .dma_ready    (dma_ready)
  );

  // dma_clk starts high so neither drive time lands on the other clock's rising edge
  always #ADC_HALF adc_clk = ~adc_clk;
  always #DMA_HALF dma_clk = ~dma_clk;

  // **************************************************
  // compare tasks
  // **************************************************

  task automatic check_word(input string name, input dma_word_t exp, input dma_word_t act);
    if (act !== exp) begin
      word_errs++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input dma_count_t exp, input dma_count_t act);
    if (act !== exp) begin
      count_errs++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      valid_errs++;
      $display("[FAIL] %s: expected dma_valid %b, actual %b", name, exp, act);
    end
  endtask

  // one sample becomes MEM_RATIO words with the low lane first
  function automatic void push_lanes(input adc_sample_t sample);
    for (int lane = 0; lane < MEM_RATIO; lane++) begin
      exp_words.push_back(sample[lane*DMA_DATA_WIDTH +: DMA_DATA_WIDTH]);
    end
  endfunction

  // **************************************************
  // ADC side model and driver
  // **************************************************

  // enable follows the request by 3 edges and capture holds at most ADC_DEPTH samples
  always @(posedge adc_clk) begin
    if (mdl_en && adc_wr) begin
      push_lanes(adc_wdata);
      cap_cnt++;
      if (cap_cnt == ADC_DEPTH) begin
        mdl_en = 1'b0;
      end
    end
    if (adc_rst || !dma_xfer_req) begin
      req_edges = 0;
      mdl_en = 1'b0;
    end else if (req_edges < ENABLE_DELAY) begin
      req_edges++;
      if (req_edges == ENABLE_DELAY) begin
        mdl_en = 1'b1;
        cap_cnt = 0;
      end
    end
    #DRIVE_DELAY;
    adc_wr = ($unsigned($random(wr_seed)) % 100) < 50;
    adc_wdata = {$random(wr_seed), $random(wr_seed)};
  end

  // **************************************************
  // DMA side ready driver and stream monitor
  // **************************************************

  always @(posedge dma_clk) begin
    #DRIVE_DELAY;
    if (ready_random) begin
      dma_ready = ($unsigned($random(ready_seed)) % 100) < 60;
    end else begin
      dma_ready = 1'b1;
    end
  end

  // the handshake seen at mid-cycle is the one the next rising edge takes
  always @(negedge dma_clk) begin
    if (dma_xfer_req && dma_valid && dma_ready) begin
      if (exp_words.size() == 0) begin
        other_errs++;
        $display("ERROR: %s: word %0d arrived with no sample behind it", test_name, got_cnt);
      end else begin
        check_word($sformatf("%s word %0d", test_name, got_cnt), exp_words.pop_front(), dma_data);
      end
      got_cnt++;
    end
  end

  // **************************************************
  // sequences
  // **************************************************

  task automatic expect_idle(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge dma_clk);
      check_valid(name, 1'b0, dma_valid);
    end
  endtask

  task automatic drop_request(input string name, input int cycles);
    @(posedge dma_clk);
    #DRIVE_DELAY;
    dma_xfer_req = 1'b0;
    expect_idle(name, cycles);
  endtask

  task automatic run_capture(input string name, input logic random_ready);
    int waited;
    test_name = name;
    exp_words.delete();
    got_cnt = 0;
    waited = 0;
    ready_random = random_ready;
    @(posedge dma_clk);
    #DRIVE_DELAY;
    dma_xfer_req = 1'b1;
    while (got_cnt < DMA_DEPTH && waited < WAIT_LIMIT) begin
      @(posedge dma_clk);
      waited++;
    end
    if (got_cnt < DMA_DEPTH) begin
      other_errs++;
      $display("ERROR: %s timed out with %0d of %0d words", name, got_cnt, DMA_DEPTH);
    end
    // adc_wr keeps pulsing, yet the full capture must stay closed
    expect_idle({name, "_limit"}, 100);
    check_count({name, "_words"}, dma_count_t'(DMA_DEPTH), dma_count_t'(got_cnt));
    if (exp_words.size() != 0) begin
      other_errs++;
      $display("ERROR: %s: %0d expected words never arrived", name, exp_words.size());
    end
  endtask

  initial begin
    adc_clk = 1'b0;
    dma_clk = 1'b1;
    adc_rst = 1'b1;
    adc_wr = 1'b0;
    adc_wdata = '0;
    dma_xfer_req = 1'b0;
    dma_ready = 1'b1;
    wr_seed = SEED;
    ready_seed = SEED;
    ready_random = 1'b0;
    req_edges = 0;
    mdl_en = 1'b0;
    cap_cnt = 0;
    test_name = "reset";
    got_cnt = 0;
    word_errs = 0;
    count_errs = 0;
    valid_errs = 0;
    other_errs = 0;

    repeat (RESET_CYCLES) @(posedge adc_clk);
    #DRIVE_DELAY;
    adc_rst = 1'b0;

    expect_idle("idle_after_reset", 50);
    run_capture("capture_ready_high", 1'b0);
    drop_request("restart_gap", 10);
    run_capture("restart_random_ready", 1'b1);
    drop_request("final_idle", 10);

    $display("errors: word %0d, count %0d, valid %0d, other %0d",
             word_errs, count_errs, valid_errs, other_errs);
    if (word_errs + count_errs + valid_errs + other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: adc_capture_fifo.f
common/adcfifo_pkg.sv
design/asym_dpram.sv
adc_capture/adc_capture_ctrl.sv
dma_readout/dma_read_ctrl.sv
dma_readout/dma_stream_buffer.sv
design/adc_capture_fifo.sv
verification/adc_capture_fifo_sva.sv
verification/tb_adc_capture_fifo.sv

// File: Makefile
TOP := tb_adc_capture_fifo
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

obj_dir/V$(TOP): adc_capture_fifo.f $(shell cat adc_capture_fifo.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f adc_capture_fifo.f

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "run ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
